/* hw/axi_lite_pkg.sv */
/* AXI4-Lite channel types for a 32-bit data bus with byte strobes
   only OKAY and SLVERR responses are produced; no AxPROT field */
package axi_lite_pkg;

    localparam int AXI_ADDR_W = 32;
    localparam int AXI_DATA_W = 32;
    localparam int AXI_STRB_W = AXI_DATA_W / 8;

    typedef logic [AXI_ADDR_W-1:0] axi_addr_t;   // byte address
    typedef logic [AXI_DATA_W-1:0] axi_data_t;
    typedef logic [AXI_STRB_W-1:0] axi_strb_t;   // one bit per byte lane
    typedef logic [1:0]            axi_resp_t;

    localparam axi_resp_t RESP_OKAY   = 2'b00;
    localparam axi_resp_t RESP_SLVERR = 2'b10;

    // read address
    typedef struct packed {
        axi_addr_t addr;
    } axi_ar_t;

    // write address
    typedef struct packed {
        axi_addr_t addr;
    } axi_aw_t;

    typedef struct packed {
        axi_data_t data;
        axi_strb_t strb;
    } axi_w_t;

    typedef struct packed {
        axi_data_t data;
        axi_resp_t resp;
    } axi_r_t;

    // write response
    typedef struct packed {
        axi_resp_t resp;
    } axi_b_t;

endpackage

/* hw/mem_req_pkg.sv */
/* cache-side single-word request and response, built on the AXI4-Lite types
   wdata and strb are ignored for reads */
package mem_req_pkg;

    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } mem_op_e;

    typedef struct packed {
        mem_op_e               op;
        axi_lite_pkg::axi_addr_t addr;
        axi_lite_pkg::axi_data_t wdata;
        axi_lite_pkg::axi_strb_t strb;
    } mem_req_t;

    typedef struct packed {
        axi_lite_pkg::axi_data_t rdata;   // zero for writes
        logic                    err;     // response was not OKAY
    } mem_rsp_t;

endpackage

/* hw/axi_lite_ctrl.sv */
/* one AXI4-Lite transaction at a time; read or write must be held high until done
   and the two are never requested together */
`timescale 1ns/1ps

module axi_lite_ctrl (
    input  logic clk,
    input  logic reset,
    input  logic read,        // level, held until done
    input  logic write,       // level, held until done
    input  logic s_arready,
    input  logic s_rvalid,
    input  logic s_awready,
    input  logic s_wready,
    input  logic s_bvalid,
    output logic m_arvalid,
    output logic m_rready,
    output logic m_awvalid,
    output logic m_wvalid,
    output logic m_bready,
    output logic done         // single cycle, response handshake
);

    typedef enum logic [2:0] {
        IDLE,
        WAIT_READ_READY,
        WAIT_S_RVALID,
        WAIT_WRITE_READY,
        WAIT_WRITE_ADDR_READY,
        WAIT_WRITE_DATA_READY,
        WAIT_S_BVALID
    } state_e;

    state_e c_state;
    state_e n_state;

    // aw and w may be accepted in either order or on the same cycle
    function automatic state_e write_step(logic aw_rdy, logic w_rdy);
        case ({aw_rdy, w_rdy})
            2'b11:   return WAIT_S_BVALID;
            2'b10:   return WAIT_WRITE_DATA_READY;   // address taken, data pending
            2'b01:   return WAIT_WRITE_ADDR_READY;
            default: return WAIT_WRITE_READY;
        endcase
    endfunction

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            c_state <= IDLE;
        end else begin
            c_state <= n_state;
        end
    end

    always_comb begin
        n_state = c_state;
        case (c_state)
            IDLE: begin
                if (read) begin
                    n_state = s_arready ? WAIT_S_RVALID : WAIT_READ_READY;
                end else if (write) begin
                    n_state = write_step(s_awready, s_wready);
                end
            end
            WAIT_READ_READY:       if (s_arready) n_state = WAIT_S_RVALID;
            WAIT_S_RVALID:         if (s_rvalid)  n_state = IDLE;
            WAIT_WRITE_READY:      n_state = write_step(s_awready, s_wready);
            WAIT_WRITE_ADDR_READY: if (s_awready) n_state = WAIT_S_BVALID;
            WAIT_WRITE_DATA_READY: if (s_wready)  n_state = WAIT_S_BVALID;
            WAIT_S_BVALID:         if (s_bvalid)  n_state = IDLE;
            default:               n_state = IDLE;
        endcase
    end

    // valids go out in IDLE already so a ready slave accepts on the first cycle
    always_comb begin
        m_arvalid = 1'b0;
        m_rready  = 1'b0;
        m_awvalid = 1'b0;
        m_wvalid  = 1'b0;
        m_bready  = 1'b0;
        case (c_state)
            IDLE: begin
                if (read) begin
                    m_arvalid = 1'b1;
                    m_rready  = 1'b1;
                end else if (write) begin
                    m_awvalid = 1'b1;
                    m_wvalid  = 1'b1;
                    m_bready  = 1'b1;
                end
            end
            WAIT_READ_READY: begin
                m_arvalid = 1'b1;
                m_rready  = 1'b1;
            end
            WAIT_S_RVALID: m_rready = 1'b1;
            WAIT_WRITE_READY: begin
                m_awvalid = 1'b1;
                m_wvalid  = 1'b1;
                m_bready  = 1'b1;
            end
            WAIT_WRITE_ADDR_READY: begin
                m_awvalid = 1'b1;
                m_bready  = 1'b1;
            end
            WAIT_WRITE_DATA_READY: begin
                m_wvalid  = 1'b1;
                m_bready  = 1'b1;
            end
            WAIT_S_BVALID: m_bready = 1'b1;
            default: ;
        endcase
    end

    assign done = (c_state == WAIT_S_RVALID && s_rvalid) ||
                  (c_state == WAIT_S_BVALID && s_bvalid);

    // relies on the requester holding write until done
    aw_valid_held: assert property (@(posedge clk) disable iff (!reset)
        m_awvalid && !s_awready |=> m_awvalid)
        else $error("axi_lite_ctrl: awvalid dropped before awready");

    single_request: assert property (@(posedge clk) disable iff (!reset)
        c_state == IDLE |-> !(read && write))
        else $error("axi_lite_ctrl: read and write requested together");

endmodule

/* hw/axi_lite_master.sv */
/* four-phase req/ack port onto AXI4-Lite, one request in flight
   req_data must stay stable from req rising until ack; AxPROT is not driven */
`timescale 1ns/1ps

module axi_lite_master
    import axi_lite_pkg::*;
    import mem_req_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     req,
    input  mem_req_t req_data,
    output logic     ack,
    output mem_rsp_t rsp,
    output logic     ar_valid,
    input  logic     ar_ready,
    output axi_ar_t  ar,
    output logic     aw_valid,
    input  logic     aw_ready,
    output axi_aw_t  aw,
    output logic     w_valid,
    input  logic     w_ready,
    output axi_w_t   w,
    input  logic     r_valid,
    output logic     r_ready,
    input  axi_r_t   r,
    input  logic     b_valid,
    output logic     b_ready,
    input  axi_b_t   b
);

    typedef enum logic [1:0] {
        IDLE,
        BUSY,
        ACKED
    } state_e;

    state_e    state;
    mem_req_t  req_q;
    mem_rsp_t  rsp_q;
    logic      is_read;
    logic      ctrl_read;
    logic      ctrl_write;
    logic      done;
    axi_resp_t resp;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:    if (req)  state <= BUSY;
                BUSY:    if (done) state <= ACKED;
                ACKED:   if (!req) state <= IDLE;   // ack drops the cycle after req
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && req) begin
            req_q <= req_data;
        end
        if (state == BUSY && done) begin
            rsp_q.rdata <= is_read ? r.data : '0;
            rsp_q.err   <= (resp != RESP_OKAY);
        end
    end

    assign is_read    = (req_q.op == OP_READ);
    assign resp       = is_read ? r.resp : b.resp;
    assign ctrl_read  = (state == BUSY) && is_read;
    assign ctrl_write = (state == BUSY) && !is_read;

    assign ack = (state == ACKED);
    assign rsp = rsp_q;

    assign ar.addr = req_q.addr;
    assign aw.addr = req_q.addr;
    assign w.data  = req_q.wdata;
    assign w.strb  = req_q.strb;

    axi_lite_ctrl u_ctrl (
        .clk       (clk),
        .reset     (reset),
        .read      (ctrl_read),
        .write     (ctrl_write),
        .s_arready (ar_ready),
        .s_rvalid  (r_valid),
        .s_awready (aw_ready),
        .s_wready  (w_ready),
        .s_bvalid  (b_valid),
        .m_arvalid (ar_valid),
        .m_rready  (r_ready),
        .m_awvalid (aw_valid),
        .m_wvalid  (w_valid),
        .m_bready  (b_ready),
        .done      (done)
    );

    req_data_stable: assert property (@(posedge clk) disable iff (!reset)
        (req && !ack) ##1 (req && !ack) |-> $stable(req_data))
        else $error("axi_lite_master: req_data changed before ack");

endmodule

/* hw/axi_lite_mem_slave.sv */
/* word memory behind an AXI4-Lite slave, one transaction at a time, cleared at reset
   word index at or beyond MEM_WORDS gives SLVERR; waits above 255 cycles unsupported */
`timescale 1ns/1ps

module axi_lite_mem_slave
    import axi_lite_pkg::*;
#(
    parameter int MEM_WORDS = 64,
    parameter int AR_WAIT   = 1,
    parameter int AW_WAIT   = 2,
    parameter int W_WAIT    = 0,
    parameter int RESP_WAIT = 1
) (
    input  logic    clk,
    input  logic    reset,
    input  logic    ar_valid,
    output logic    ar_ready,
    input  axi_ar_t ar,
    input  logic    aw_valid,
    output logic    aw_ready,
    input  axi_aw_t aw,
    input  logic    w_valid,
    output logic    w_ready,
    input  axi_w_t  w,
    output logic    r_valid,
    input  logic    r_ready,
    output axi_r_t  r,
    output logic    b_valid,
    input  logic    b_ready,
    output axi_b_t  b
);

    localparam int        IDX_W      = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;
    localparam axi_addr_t WORD_LIMIT = axi_addr_t'(MEM_WORDS);

    typedef logic [7:0]       wait_cnt_t;
    typedef logic [IDX_W-1:0] word_idx_t;

    axi_data_t mem [MEM_WORDS];
    wait_cnt_t ar_cnt, aw_cnt, w_cnt, rsp_cnt;
    logic      rd_pend, wr_pend, aw_got, w_got, busy;
    logic      ar_fire, aw_fire, w_fire, r_fire, b_fire, wr_commit;
    axi_addr_t aw_addr_q, wr_addr;
    axi_w_t    w_q, wr_w;

    // counts while active, parks at the limit, clears when idle
    function automatic wait_cnt_t cnt_step(wait_cnt_t cnt, logic active, int lim);
        if (!active) return '0;
        if (cnt == wait_cnt_t'(lim)) return cnt;
        return cnt + 8'd1;
    endfunction

    function automatic logic in_range(axi_addr_t a);
        return (a >> 2) < WORD_LIMIT;
    endfunction

    function automatic word_idx_t word_idx(axi_addr_t a);
        return a[IDX_W+1:2];
    endfunction

    assign busy     = rd_pend || wr_pend;
    assign ar_ready = ar_valid && !busy && (ar_cnt == wait_cnt_t'(AR_WAIT));
    assign aw_ready = aw_valid && !busy && !aw_got && (aw_cnt == wait_cnt_t'(AW_WAIT));
    assign w_ready  = w_valid && !busy && !w_got && (w_cnt == wait_cnt_t'(W_WAIT));
    assign r_valid  = rd_pend && (rsp_cnt == wait_cnt_t'(RESP_WAIT));
    assign b_valid  = wr_pend && (rsp_cnt == wait_cnt_t'(RESP_WAIT));

    assign ar_fire = ar_valid && ar_ready;
    assign aw_fire = aw_valid && aw_ready;
    assign w_fire  = w_valid && w_ready;
    assign r_fire  = r_valid && r_ready;
    assign b_fire  = b_valid && b_ready;

    // the write completes on whichever of aw and w arrives last
    assign wr_commit = (aw_got || aw_fire) && (w_got || w_fire);
    assign wr_addr   = aw_got ? aw_addr_q : aw.addr;
    assign wr_w      = w_got ? w_q : w;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            ar_cnt  <= '0;
            aw_cnt  <= '0;
            w_cnt   <= '0;
            rsp_cnt <= '0;
            rd_pend <= 1'b0;
            wr_pend <= 1'b0;
            aw_got  <= 1'b0;
            w_got   <= 1'b0;
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else begin
            ar_cnt  <= cnt_step(ar_cnt, ar_valid && !ar_ready, AR_WAIT);
            aw_cnt  <= cnt_step(aw_cnt, aw_valid && !aw_ready, AW_WAIT);
            w_cnt   <= cnt_step(w_cnt, w_valid && !w_ready, W_WAIT);
            rsp_cnt <= cnt_step(rsp_cnt, (rd_pend && !r_fire) || (wr_pend && !b_fire),
                                RESP_WAIT);

            if (ar_fire) rd_pend <= 1'b1;
            else if (r_fire) rd_pend <= 1'b0;

            if (wr_commit) begin
                aw_got  <= 1'b0;
                w_got   <= 1'b0;
                wr_pend <= 1'b1;
            end else begin
                if (aw_fire) aw_got <= 1'b1;
                if (w_fire) w_got <= 1'b1;
                if (b_fire) wr_pend <= 1'b0;
            end

            if (wr_commit && in_range(wr_addr)) begin   // out of range writes dropped
                for (int i = 0; i < AXI_STRB_W; i++) begin
                    if (wr_w.strb[i]) mem[word_idx(wr_addr)][8*i +: 8] <= wr_w.data[8*i +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (aw_fire) aw_addr_q <= aw.addr;
        if (w_fire) w_q <= w;
        if (ar_fire) begin
            r.data <= in_range(ar.addr) ? mem[word_idx(ar.addr)] : '0;
            r.resp <= in_range(ar.addr) ? RESP_OKAY : RESP_SLVERR;
        end
        if (wr_commit) b.resp <= in_range(wr_addr) ? RESP_OKAY : RESP_SLVERR;
    end

    r_held: assert property (@(posedge clk) disable iff (!reset)
        r_valid && !r_ready |=> r_valid && $stable(r))
        else $error("axi_lite_mem_slave: read response changed before rready");

endmodule

/* hw/axi_mem_subsys.sv */
/* cache-side memory port, AXI4-Lite master wired to a small slave memory
   four-phase req/ack on the outside, latency set by the slave waits */
`timescale 1ns/1ps

module axi_mem_subsys
    import axi_lite_pkg::*;
    import mem_req_pkg::*;
#(
    parameter int MEM_WORDS = 64,
    parameter int AR_WAIT   = 1,
    parameter int AW_WAIT   = 2,   // differs from W_WAIT on purpose
    parameter int W_WAIT    = 0,
    parameter int RESP_WAIT = 1
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     req,
    input  mem_req_t req_data,
    output logic     ack,
    output mem_rsp_t rsp
);

    logic    ar_valid, ar_ready, aw_valid, aw_ready, w_valid, w_ready;
    logic    r_valid, r_ready, b_valid, b_ready;
    axi_ar_t ar;
    axi_aw_t aw;
    axi_w_t  w;
    axi_r_t  r;
    axi_b_t  b;

    axi_lite_master u_master (
        .clk      (clk),
        .reset    (reset),
        .req      (req),
        .req_data (req_data),
        .ack      (ack),
        .rsp      (rsp),
        .ar_valid (ar_valid),
        .ar_ready (ar_ready),
        .ar       (ar),
        .aw_valid (aw_valid),
        .aw_ready (aw_ready),
        .aw       (aw),
        .w_valid  (w_valid),
        .w_ready  (w_ready),
        .w        (w),
        .r_valid  (r_valid),
        .r_ready  (r_ready),
        .r        (r),
        .b_valid  (b_valid),
        .b_ready  (b_ready),
        .b        (b)
    );

    axi_lite_mem_slave #(
        .MEM_WORDS (MEM_WORDS),
        .AR_WAIT   (AR_WAIT),
        .AW_WAIT   (AW_WAIT),
        .W_WAIT    (W_WAIT),
        .RESP_WAIT (RESP_WAIT)
    ) u_mem (
        .clk      (clk),
        .reset    (reset),
        .ar_valid (ar_valid),
        .ar_ready (ar_ready),
        .ar       (ar),
        .aw_valid (aw_valid),
        .aw_ready (aw_ready),
        .aw       (aw),
        .w_valid  (w_valid),
        .w_ready  (w_ready),
        .w        (w),
        .r_valid  (r_valid),
        .r_ready  (r_ready),
        .r        (r),
        .b_valid  (b_valid),
        .b_ready  (b_ready),
        .b        (b)
    );

endmodule

/* dv/axi_mem_subsys_tb.sv */
/* drives axi_mem_subsys from dv/axi_stim.txt through the four-phase req/ack port
   assumes the default top-level parameters (64 words); run from the project root */
`timescale 1ns/1ps

module axi_mem_subsys_tb
    import axi_lite_pkg::*;
    import mem_req_pkg::*;
();

    localparam string STIM_FILE   = "dv/axi_stim.txt";
    localparam int    RESET_CYC   = 16;
    localparam int    TXN_CYC_MAX = 64;   // watchdog budget per transaction

    typedef struct packed {
        mem_req_t  txn;
        axi_data_t exp_rdata;
        logic      exp_err;
    } stim_t;

    logic     clk;
    logic     reset;
    logic     req;
    mem_req_t req_data;
    logic     ack;
    mem_rsp_t rsp;

    stim_t    stim_q[$];
    logic     stim_ready = 1'b0;
    int       pass_cnt   = 0;
    int       fail_cnt   = 0;
    int       proto_errs = 0;
    int       load_errs  = 0;
    logic     ack_prev   = 1'b0;
    logic     req_prev   = 1'b0;
    mem_rsp_t rsp_prev   = '0;

    axi_mem_subsys uut (
        .clk      (clk),
        .reset    (reset),
        .req      (req),
        .req_data (req_data),
        .ack      (ack),
        .rsp      (rsp)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic load_stim(output logic ok);
        int          fd;
        int          n;
        string       line;
        logic [31:0] f_op, f_addr, f_data, f_strb, f_rdata, f_err;
        stim_t       s;
        ok = 1'b0;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("cannot open stimulus file %s", STIM_FILE);
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 1 && line.getc(0) != 8'h23) begin   // '#' starts a comment
                    n = $sscanf(line, "%h %h %h %h %h %h",
                                f_op, f_addr, f_data, f_strb, f_rdata, f_err);
                    if (n == 6) begin
                        s.txn.op    = mem_op_e'(f_op[0]);
                        s.txn.addr  = f_addr;
                        s.txn.wdata = f_data;
                        s.txn.strb  = f_strb[3:0];
                        s.exp_rdata = f_rdata;
                        s.exp_err   = f_err[0];
                        stim_q.push_back(s);
                    end else begin
                        $display("malformed stimulus line: %s", line);
                        load_errs++;
                    end
                end
            end
            $fclose(fd);
            ok = (stim_q.size() > 0);
        end
    endtask

    // one full req/ack cycle, response checked while ack is high
    task automatic run_txn(input stim_t s, input int idx);
        mem_rsp_t got;
        logic     test_ok;
        int       cycles;
        test_ok = 1'b1;
        @(posedge clk);
        req_data <= s.txn;
        req      <= 1'b1;
        do begin
            @(negedge clk);
        end while (!ack);
        got = rsp;
        assert (got.rdata == s.exp_rdata)
            else begin
                $display("error at %0t: rsp.rdata got %08h expected %08h",
                         $time, got.rdata, s.exp_rdata);
                test_ok = 1'b0;
            end
        assert (got.err == s.exp_err)
            else begin
                $display("error at %0t: rsp.err got %0b expected %0b", $time, got.err, s.exp_err);
                test_ok = 1'b0;
            end
        @(posedge clk);
        req    <= 1'b0;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (ack && cycles < 3);
        assert (!ack)
            else begin
                $display("ack still high %0d cycles after req fell in test %0d", cycles, idx);
                test_ok = 1'b0;
            end
        $display("test %0d %s addr %08h: %s", idx, (s.txn.op == OP_WRITE) ? "write" : "read",
                 s.txn.addr, test_ok ? "ok" : "FAILED");
        if (test_ok) pass_cnt++;
        else fail_cnt++;
    endtask

    // handshake rules, sampled mid-cycle
    always @(negedge clk) begin
        if (reset) begin
            if (ack && !ack_prev) begin
                assert (req)
                    else begin
                        $display("ack rose at %0t while req was low", $time);
                        proto_errs++;
                    end
            end
            if (ack && ack_prev) begin
                assert (rsp == rsp_prev)
                    else begin
                        $display("error at %0t: rsp got %h expected %h", $time, rsp, rsp_prev);
                        proto_errs++;
                    end
            end
            if (!ack && ack_prev) begin
                assert (!req_prev)
                    else begin
                        $display("ack fell at %0t before req fell", $time);
                        proto_errs++;
                    end
            end
        end
        ack_prev = ack;
        req_prev = req;
        rsp_prev = rsp;
    end

    initial begin
        wait (stim_ready);
        repeat (RESET_CYC + stim_q.size() * TXN_CYC_MAX) @(posedge clk);
        $display("timeout: transactions still running after %0d cycles",
                 RESET_CYC + stim_q.size() * TXN_CYC_MAX);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        logic loaded;
        reset    = 1'b0;
        req      = 1'b0;
        req_data = '0;
        load_stim(loaded);
        if (!loaded) begin
            $display("no usable stimulus read from %s", STIM_FILE);
            $display("=== FAIL ===");
            $finish;
        end else begin
            stim_ready = 1'b1;
            repeat (RESET_CYC) @(posedge clk);
            reset <= 1'b1;
            foreach (stim_q[i]) begin
                run_txn(stim_q[i], i);
            end
            $display("%0d tests, %0d passed, %0d failed, %0d handshake errors, %0d bad lines",
                     stim_q.size(), pass_cnt, fail_cnt, proto_errs, load_errs);
            if (fail_cnt == 0 && proto_errs == 0 && load_errs == 0) begin
                $display("=== PASS ===");
            end else begin
                $display("=== FAIL ===");
            end
            $finish;
        end
    end

endmodule

/* dv/axi_stim.txt */
# op (0 read, 1 write)  addr  wdata  strb  expected rdata  expected err, all hex
# 64-word memory: byte addresses 000..0fc are in range, writes answer with rdata 0
0 00000010 00000000 0 00000000 0
1 00000000 11223344 f 00000000 0
0 00000000 00000000 0 11223344 0
1 00000004 a5a5a5a5 f 00000000 0
1 00000004 0000beef 3 00000000 0
0 00000004 00000000 0 a5a5beef 0
1 00000004 12000000 8 00000000 0
0 00000004 00000000 0 12a5beef 0
1 000000fc cafef00d f 00000000 0
0 000000fc 00000000 0 cafef00d 0
# out of range, word index would alias word 0
1 00000100 deadbeef f 00000000 1
0 00000100 00000000 0 00000000 1
0 00000000 00000000 0 11223344 0
1 00001000 ffffffff f 00000000 1
0 00000000 00000000 0 11223344 0
0 000000fc 00000000 0 cafef00d 0
1 00000080 00ff0000 4 00000000 0
0 00000080 00000000 0 00ff0000 0
1 00000080 77000011 9 00000000 0
0 00000080 00000000 0 77ff0011 0
0 00000084 00000000 0 00000000 0
0 fffffffc 00000000 0 00000000 1
0 00000004 00000000 0 12a5beef 0

/* compile.f */
hw/axi_lite_pkg.sv
hw/mem_req_pkg.sv
hw/axi_lite_ctrl.sv
hw/axi_lite_master.sv
hw/axi_lite_mem_slave.sv
hw/axi_mem_subsys.sv
dv/axi_mem_subsys_tb.sv

/* run.sh */
#!/bin/sh
# build and run the testbench with Verilator, from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f compile.f --top-module axi_mem_subsys_tb -o axi_sim

out=$(./obj_dir/axi_sim) || true
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -qx '=== PASS ==='; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
